/* rtl/mcu_pkg.sv */
`default_nettype none

package mcu_pkg;

   localparam int CODE_DEPTH = 512;             // code memory locations

   typedef logic [$clog2(CODE_DEPTH)-1:0] code_addr_t;
   typedef logic [7:0]                    byte_t;
   typedef logic [15:0]                   dptr_t;

   // reduced 8051 opcode set
   typedef enum logic [7:0] {
      LJMP   = 8'h02,   // ljmp addr16
      INCA   = 8'h04,
      RRC    = 8'h13,
      DECA   = 8'h14,
      ADDAI  = 8'h24,   // add a,#imm
      RLC    = 8'h33,
      JC     = 8'h40,
      JNC    = 8'h50,
      JZ     = 8'h60,
      XRLA   = 8'h64,   // xrl a,#imm
      JNZ    = 8'h70,
      MOVAI  = 8'h74,   // mov a,#imm
      SJMP   = 8'h80,
      MOVDP  = 8'h90,   // mov dptr,#imm16
      SUBBAI = 8'h94,   // subb a,#imm
      CLRC   = 8'hC3,
      SETBC  = 8'hD3,
      MOVXAD = 8'hE0,   // movx a,@dptr
      CLRA   = 8'hE4,
      MOVXDA = 8'hF0,   // movx @dptr,a
      CPLA   = 8'hF4
   } opcode_e;

   typedef enum logic [2:0] {
      FETCH   = 3'd0,
      DECODE0 = 3'd1,
      DECODE1 = 3'd2,
      DECODE2 = 3'd3,
      EXECUTE = 3'd4
   } cpu_state_e;

   // memory mapped uart
   localparam dptr_t TX_STATUS_ADDR = 16'h0200;   // bit 0 is tx busy
   localparam dptr_t TX_DATA_ADDR   = 16'h0201;

endpackage

`default_nettype wire

/* rtl/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx import mcu_pkg::*; #(
   parameter int CLKS_PER_BIT = 104
) (
   input  logic  i_clk,
   input  logic  i_nrst,
   input  logic  i_rx,
   output logic  o_valid,
   output byte_t o_byte
);

   localparam int CW = $clog2(CLKS_PER_BIT);
   localparam logic [CW-1:0] LAST = CW'(CLKS_PER_BIT - 1);
   localparam logic [CW-1:0] HALF = CW'(CLKS_PER_BIT / 2 - 1);   // start bit centre

   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

   rx_state_e     state;
   logic          rx_s;       // resynced line
   logic [CW-1:0] cnt;
   byte_t         shreg;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_s <= 1'b1;         // line idles high
      end else begin
         rx_s <= i_rx;
      end
   end

   //////////////////////////////
   // frame fsm
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state   <= RX_IDLE;
         cnt     <= '0;
         o_valid <= 1'b0;
      end else begin
         o_valid <= 1'b0;
         cnt     <= cnt + CW'(1);
         case (state)
            RX_IDLE: begin
               cnt <= '0;
               if (!rx_s) state <= RX_START;
            end
            RX_START: begin
               if (cnt == HALF) begin
                  cnt   <= '0;
                  state <= rx_s ? RX_IDLE : RX_DATA;   // back to idle on a glitch
               end
            end
            RX_DATA: begin
               if (cnt == LAST) begin
                  cnt <= '0;
                  // marker in bit 0 means this is the eighth bit
                  if (shreg[0]) state <= RX_STOP;
               end
            end
            default: begin   // pulse at the stop bit centre
               if (cnt == LAST) begin
                  o_valid <= 1'b1;
                  state   <= RX_IDLE;
               end
            end
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (state == RX_START && cnt == HALF) begin
         shreg <= 8'h80;                  // marker bit
      end else if (state == RX_DATA && cnt == LAST) begin
         shreg <= {rx_s, shreg[7:1]};     // lsb first
      end
   end

   assign o_byte = shreg;

endmodule

`default_nettype wire

/* rtl/code_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module code_loader import mcu_pkg::*; #(
   parameter int LOAD_BYTES = CODE_DEPTH
) (
   input  logic       i_clk,
   input  logic       i_nrst,
   input  logic       i_valid,
   input  byte_t      i_byte,
   input  code_addr_t i_fetch_addr,
   output logic       o_code_wr,
   output code_addr_t o_code_addr,
   output byte_t      o_code_data,
   output logic       o_boot_done
);

   code_addr_t wr_addr;     // bytes received so far
   logic       boot_done;
   logic       last_byte;

   assign last_byte = (wr_addr == code_addr_t'(LOAD_BYTES - 1));
   assign o_code_wr = i_valid & ~boot_done;   // late bytes are dropped

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         wr_addr   <= '0;
         boot_done <= 1'b0;
      end else if (o_code_wr) begin
         wr_addr <= wr_addr + code_addr_t'(1);
         if (last_byte) boot_done <= 1'b1;
      end
   end

   // core owns the address once loaded
   assign o_code_addr = boot_done ? i_fetch_addr : wr_addr;
   assign o_code_data = i_byte;
   assign o_boot_done = boot_done;

endmodule

`default_nettype wire

/* rtl/cpu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_core import mcu_pkg::*; (
   input  logic       i_clk,
   input  logic       i_nrst,
   input  logic       i_boot_done,
   input  byte_t      i_code_data,
   input  logic       i_tx_busy,
   output code_addr_t o_fetch_addr,
   output logic       o_tx_start,
   output byte_t      o_tx_byte
);

   cpu_state_e state;
   cpu_state_e state_next;
   code_addr_t pc;
   code_addr_t pc_next;
   logic       pc_step;
   byte_t      acc;
   byte_t      acc_next;
   logic       carry;
   logic       carry_next;
   dptr_t      dptr;
   dptr_t      dptr_next;
   byte_t      op_q;          // opcode
   byte_t      op1_q;         // first operand byte
   byte_t      op2_q;         // second operand byte
   logic [8:0] sum;
   logic [8:0] diff;
   code_addr_t rel_target;
   logic       acc_zero;

   function automatic logic has_operand(byte_t op);
      case (op)
         ADDAI, SUBBAI, XRLA, MOVAI, JC, JNC, JZ, JNZ, SJMP,
         LJMP, MOVDP: has_operand = 1'b1;
         default:     has_operand = 1'b0;
      endcase
   endfunction

   function automatic logic is_long(byte_t op);
      is_long = (op == LJMP) || (op == MOVDP);   // 3-byte forms
   endfunction

   //////////////////////////////
   // sequencer
   always_comb begin
      state_next = state;
      case (state)
         FETCH:   if (i_boot_done) state_next = DECODE0;
         DECODE0: state_next = has_operand(i_code_data) ? DECODE1 : EXECUTE;
         DECODE1: state_next = is_long(op_q) ? DECODE2 : EXECUTE;
         DECODE2: state_next = EXECUTE;
         default: state_next = FETCH;
      endcase
   end

   // pc runs one byte ahead of the data coming back
   assign pc_step = (state == FETCH && i_boot_done) ||
                    (state == DECODE0 && has_operand(i_code_data)) ||
                    (state == DECODE1 && is_long(op_q));

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= FETCH;
         pc    <= '0;
         acc   <= '0;
         carry <= 1'b0;
         dptr  <= '0;
      end else begin
         state <= state_next;
         if (state == EXECUTE) begin
            pc    <= pc_next;
            acc   <= acc_next;
            carry <= carry_next;
            dptr  <= dptr_next;
         end else if (pc_step) begin
            pc <= pc + code_addr_t'(1);   // wraps at 9 bits
         end
      end
   end

   always_ff @(posedge i_clk) begin
      case (state)
         DECODE0: op_q  <= i_code_data;
         DECODE1: op1_q <= i_code_data;
         DECODE2: op2_q <= i_code_data;
         default: ;
      endcase
   end

   //////////////////////////////
   // execute
   assign sum        = {1'b0, acc} + {1'b0, op1_q};
   assign diff       = {1'b0, acc} - {1'b0, op1_q} - {8'h00, carry};   // bit 8 is borrow
   assign rel_target = pc + {op1_q[7], op1_q};     // pc already past the operand
   assign acc_zero   = (acc == 8'h00);

   always_comb begin
      acc_next   = acc;
      carry_next = carry;
      dptr_next  = dptr;
      pc_next    = pc;
      case (op_q)
         MOVAI:  acc_next = op1_q;
         ADDAI:  {carry_next, acc_next} = sum;
         SUBBAI: {carry_next, acc_next} = diff;
         XRLA:   acc_next = acc ^ op1_q;
         INCA:   acc_next = acc + 8'd1;
         DECA:   acc_next = acc - 8'd1;
         CLRA:   acc_next = 8'h00;
         CPLA:   acc_next = ~acc;
         RLC:    {carry_next, acc_next} = {acc, carry};   // through carry
         RRC:    {acc_next, carry_next} = {carry, acc};
         CLRC:   carry_next = 1'b0;
         SETBC:  carry_next = 1'b1;
         LJMP:   pc_next = {op1_q[0], op2_q};             // low 9 bits of target
         SJMP:   pc_next = rel_target;
         JC:     if (carry) pc_next = rel_target;
         JNC:    if (!carry) pc_next = rel_target;
         JZ:     if (acc_zero) pc_next = rel_target;
         JNZ:    if (!acc_zero) pc_next = rel_target;
         MOVDP:  dptr_next = {op1_q, op2_q};
         // only the uart status reads back something
         MOVXAD: acc_next = (dptr == TX_STATUS_ADDR) ? {7'h00, i_tx_busy} : 8'h00;
         default: ;   // movx write and unknown opcodes
      endcase
   end

   // write to the data port kicks the transmitter
   assign o_tx_start   = (state == EXECUTE) && (op_q == MOVXDA) && (dptr == TX_DATA_ADDR);
   assign o_tx_byte    = acc;
   assign o_fetch_addr = pc;

endmodule

`default_nettype wire

/* rtl/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx import mcu_pkg::*; #(
   parameter int CLKS_PER_BIT = 104
) (
   input  logic  i_clk,
   input  logic  i_nrst,
   input  logic  i_start,
   input  byte_t i_byte,
   output logic  o_tx,
   output logic  o_busy
);

   localparam int CW = $clog2(CLKS_PER_BIT);
   localparam logic [CW-1:0] LAST = CW'(CLKS_PER_BIT - 1);

   typedef enum logic [1:0] {TX_IDLE, TX_START, TX_SEND} tx_state_e;

   tx_state_e     state;
   logic [CW-1:0] cnt;
   logic [3:0]    nbit;       // 8 data bits then stop
   byte_t         shreg;
   logic          bit_end;

   assign bit_end = (cnt == LAST);

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= TX_IDLE;
         cnt   <= '0;
         nbit  <= '0;
      end else begin
         cnt <= bit_end ? '0 : cnt + CW'(1);
         case (state)
            TX_IDLE: begin
               cnt  <= '0;
               nbit <= '0;
               if (i_start) state <= TX_START;   // starts while busy are lost
            end
            TX_START: if (bit_end) state <= TX_SEND;
            default: begin
               if (bit_end) begin
                  nbit <= nbit + 4'd1;
                  if (nbit == 4'd8) state <= TX_IDLE;   // end of stop bit
               end
            end
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (state == TX_IDLE && i_start) begin
         shreg <= i_byte;
      end else if (state == TX_SEND && bit_end) begin
         shreg <= {1'b1, shreg[7:1]};   // ones fill in the stop bit
      end
   end

   assign o_tx   = (state == TX_IDLE) ? 1'b1 : (state == TX_START) ? 1'b0 : shreg[0];
   assign o_busy = (state != TX_IDLE);

endmodule

`default_nettype wire

/* rtl/mcu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mcu_top import mcu_pkg::*; #(
   parameter int CLKS_PER_BIT = 104,
   parameter int LOAD_BYTES   = CODE_DEPTH
) (
   input  logic       i_clk,
   input  logic       i_nrst,
   input  logic       i_uart_rx,
   output logic       o_uart_tx,
   output logic       o_code_wr,
   output code_addr_t o_code_addr,
   output byte_t      o_code_data,
   input  byte_t      i_code_data
);

   logic       rx_valid;
   byte_t      rx_byte;
   logic       boot_done;
   code_addr_t fetch_addr;
   logic       tx_start;
   byte_t      tx_byte;
   logic       tx_busy;

   //////////////////////////////
   // rx -> loader -> core -> tx
   uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_rx(i_uart_rx),
      .o_valid(rx_valid), .o_byte(rx_byte)
   );

   code_loader #(.LOAD_BYTES(LOAD_BYTES)) u_loader (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_valid(rx_valid), .i_byte(rx_byte),
      .i_fetch_addr(fetch_addr), .o_code_wr(o_code_wr), .o_code_addr(o_code_addr),
      .o_code_data(o_code_data), .o_boot_done(boot_done)
   );

   cpu_core u_core (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_boot_done(boot_done), .i_code_data(i_code_data),
      .i_tx_busy(tx_busy), .o_fetch_addr(fetch_addr), .o_tx_start(tx_start),
      .o_tx_byte(tx_byte)
   );

   uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_start(tx_start), .i_byte(tx_byte),
      .o_tx(o_uart_tx), .o_busy(tx_busy)
   );

endmodule

`default_nettype wire

/* dv/tb_mcu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mcu import mcu_pkg::*; ();

   localparam int CLKS_PER_BIT = 8;
   localparam int LOAD_BYTES   = 128;
   localparam int N_ITEMS      = 4;    // worst-case item is 31 bytes
   localparam int EXTRA_BYTES  = 2;    // sent after boot
   localparam int LIMIT = (LOAD_BYTES + EXTRA_BYTES + 2 * N_ITEMS) * 12 * CLKS_PER_BIT * 2;

   logic       i_clk       = 1'b0;
   logic       i_nrst;
   logic       i_uart_rx;
   byte_t      i_code_data = 8'h00;
   logic       o_uart_tx;
   logic       o_code_wr;
   code_addr_t o_code_addr;
   byte_t      o_code_data;

   byte_t code_mem [CODE_DEPTH];
   byte_t prog [LOAD_BYTES];    // boot image as sent
   byte_t exp_q [$];
   byte_t rx_q [$];
   byte_t alu_ops [8] = '{ADDAI, SUBBAI, XRLA, INCA, DECA, CPLA, RRC, RLC};
   int    plen     = 0;
   int    rx_count = 0;
   int    wr_count = 0;
   int    cycles   = 0;
   logic  cmp_done = 1'b0;

   mcu_top #(.CLKS_PER_BIT(CLKS_PER_BIT), .LOAD_BYTES(LOAD_BYTES)) dut0 (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_uart_rx(i_uart_rx), .o_uart_tx(o_uart_tx),
      .o_code_wr(o_code_wr), .o_code_addr(o_code_addr), .o_code_data(o_code_data),
      .i_code_data(i_code_data)
   );

   always #20 i_clk = ~i_clk;

   always @(posedge i_clk) begin   // sync code memory
      if (o_code_wr) code_mem[o_code_addr] <= o_code_data;
      i_code_data <= code_mem[o_code_addr];
   end

   //////////////////////////////
   // failure reporting and checks
   task automatic abort_run();
      $display("Test failures found");
      $fatal(1);
   endtask

   task automatic report_failure(string what);
      $display("%s at %0t", what, $time);
      abort_run();
   endtask

   task automatic check_byte(string name, byte_t exp, byte_t act);
      if (act !== exp) begin
         $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_addr(string name, code_addr_t exp, code_addr_t act);
      if (act !== exp) begin
         $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_bit(string name, logic exp, logic act);
      if (act !== exp) begin
         $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
         abort_run();
      end
   endtask

   // {carry, result} of one accumulator op
   function automatic logic [8:0] ref_alu(byte_t op, byte_t x, byte_t y, logic cin);
      int         v;
      logic [8:0] r;
      case (op)
         ADDAI: begin
            v = int'(x) + int'(y);
            r = {v > 255, 8'(v)};
         end
         SUBBAI: begin
            v = int'(x) - int'(y) - int'(cin);
            r = {v < 0, 8'(v)};     // borrow
         end
         XRLA:    r = {cin, x ^ y};
         INCA:    r = {cin, x + 8'd1};
         DECA:    r = {cin, x - 8'd1};
         CPLA:    r = {cin, ~x};
         RRC:     r = {x[0], cin, x[7:1]};
         RLC:     r = {x[7], x[6:0], cin};
         default: r = {cin, x};
      endcase
      return r;
   endfunction

   //////////////////////////////
   // program assembly
   task automatic emit_byte(byte_t b);
      prog[plen] = b;
      plen++;
   endtask

   task automatic emit_send_poll();
      emit_byte(MOVDP);
      emit_byte(TX_DATA_ADDR[15:8]);
      emit_byte(TX_DATA_ADDR[7:0]);
      emit_byte(MOVXDA);
      emit_byte(MOVDP);
      emit_byte(TX_STATUS_ADDR[15:8]);
      emit_byte(TX_STATUS_ADDR[7:0]);
      emit_byte(MOVXAD);
      emit_byte(JNZ);
      emit_byte(8'hFD);            // back to the status read
   endtask

   task automatic build_program();
      byte_t      x;
      byte_t      y;
      byte_t      op;
      logic       cin;
      int         mode;
      int         tgt;
      logic [8:0] res;
      for (int i = 0; i < N_ITEMS; i++) begin
         x    = 8'($urandom);
         y    = 8'($urandom);
         op   = alu_ops[$urandom_range(0, 7)];
         mode = $urandom_range(0, 2);
         cin  = 1'b0;              // each item ends with carry clear
         emit_byte(MOVAI);
         emit_byte(x);
         if (mode == 1) begin
            emit_byte(SETBC);
            cin = 1'b1;
         end else if (mode == 2) begin
            emit_byte(CLRC);
         end
         emit_byte(op);
         if (op == ADDAI || op == SUBBAI || op == XRLA) emit_byte(y);
         tgt = plen + 4;
         emit_byte(LJMP);
         emit_byte(8'(tgt >> 8));
         emit_byte(8'(tgt));
         emit_byte(CPLA);          // trap that the ljmp skips
         emit_send_poll();
         emit_byte(CLRA);
         emit_byte(RLC);           // carry into bit 0
         emit_send_poll();
         res = ref_alu(op, x, y, cin);
         exp_q.push_back(res[7:0]);
         exp_q.push_back({7'h00, res[8]});
      end
      emit_byte(SJMP);
      emit_byte(8'hFE);            // park here
      while (plen < LOAD_BYTES) emit_byte(8'h00);
   endtask

   task automatic send_byte(byte_t b);
      logic [9:0] frame;
      frame = {1'b1, b, 1'b0};     // stop, data, start
      for (int i = 0; i < 10; i++) begin
         @(negedge i_clk);
         i_uart_rx = frame[i];
         repeat (CLKS_PER_BIT - 1) @(negedge i_clk);
      end
   endtask

   //////////////////////////////
   // monitors
   always @(negedge i_clk) begin
      if (i_nrst && o_code_wr) begin
         if (wr_count >= LOAD_BYTES) begin
            report_failure("code memory written after boot completed");
         end else begin
            check_addr("o_code_addr", code_addr_t'(wr_count), o_code_addr);
            check_byte("o_code_data", prog[wr_count], o_code_data);
            wr_count++;
         end
      end
   end

   initial begin : uart_monitor
      byte_t b;
      forever begin
         @(negedge i_clk);
         if (i_nrst && !o_uart_tx) begin
            repeat (CLKS_PER_BIT / 2 - 1) @(negedge i_clk);   // start bit centre
            check_bit("o_uart_tx start bit", 1'b0, o_uart_tx);
            for (int i = 0; i < 8; i++) begin
               repeat (CLKS_PER_BIT) @(negedge i_clk);
               b = {o_uart_tx, b[7:1]};   // lsb first
            end
            repeat (CLKS_PER_BIT) @(negedge i_clk);
            check_bit("o_uart_tx stop bit", 1'b1, o_uart_tx);
            rx_q.push_back(b);
            rx_count++;
         end
      end
   end

   initial begin : compare
      byte_t got;
      for (int i = 0; i < 2 * N_ITEMS; i++) begin
         while (rx_q.size() == 0) @(negedge i_clk);
         got = rx_q.pop_front();
         check_byte($sformatf("o_uart_tx byte %0d", i), exp_q[i], got);
      end
      cmp_done = 1'b1;
   end

   always @(posedge i_clk) begin
      cycles++;
      if (cycles >= LIMIT) report_failure("timeout, the DUT did not finish in time");
   end

   initial begin : main
      int unsigned seed;
      seed      = $urandom(32'h108191c7);
      i_nrst    = 1'b0;
      i_uart_rx = 1'b1;
      build_program();
      repeat (10) @(posedge i_clk);
      @(negedge i_clk);
      i_nrst = 1'b1;
      repeat (20) begin            // quiet after reset
         @(negedge i_clk);
         check_bit("o_uart_tx", 1'b1, o_uart_tx);
         check_bit("o_code_wr", 1'b0, o_code_wr);
      end
      for (int i = 0; i < LOAD_BYTES; i++) send_byte(prog[i]);
      while (wr_count < LOAD_BYTES) @(negedge i_clk);
      repeat (EXTRA_BYTES) send_byte(8'($urandom));
      while (!cmp_done) @(negedge i_clk);
      repeat (2 * 10 * CLKS_PER_BIT) @(negedge i_clk);   // room for a stray frame
      if (rx_count != 2 * N_ITEMS) begin
         $display("** Error at %0t: bytes on o_uart_tx expected %0d, got %0d",
                  $time, 2 * N_ITEMS, rx_count);
         abort_run();
      end else begin
         $display("All tests passed!");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* verilog.f */
rtl/mcu_pkg.sv
rtl/uart_rx.sv
rtl/code_loader.sv
rtl/cpu_core.sv
rtl/uart_tx.sv
rtl/mcu_top.sv
dv/tb_mcu.sv

/* Makefile */
VERILATOR  = verilator
TOP        = tb_mcu
RTL_TOP    = mcu_top
FILELIST   = verilog.f
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing
LOG        = sim.log
PASS_MSG   = All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
